//--- heapPkg.sv
// Shared widths and derived counts for the array heap
// Action and error code enums
// Request, response and allocator grant structs
`default_nettype none

package heapPkg;

  localparam int AddressBits = 2;                   // Four arrays
  localparam int IndexBits   = 3;                   // Eight elements per array
  localparam int DataBits    = 12;                  // Element width
  localparam int Arrays      = 2**AddressBits;
  localparam int ArrayLength = 2**IndexBits;

  typedef logic [AddressBits-1:0] arrayT;           // Array number
  typedef logic [IndexBits-1:0]   indexT;           // Element index
  typedef logic [IndexBits:0]     sizeT;            // Holds 0 to ArrayLength
  typedef logic [DataBits-1:0]    dataT;            // Element and result word

  typedef enum logic [4:0] {
    actNone, actWrite, actRead, actSize, actInc, actDec, actIndex, actPush,
    actPop, actResize, actAlloc, actFree, actAdd, actAddAfter, actSubtract,
    actSubAfter, actShiftLeft, actShiftRight, actNotLogical, actNot, actOr,
    actXor, actAnd
  } heapActionT;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds, errFull, errEmpty,
    errOutOfMemory
  } heapErrorT;

  typedef heapErrorT accessT;                       // Only the first three codes

  typedef struct packed {
    heapActionT action;
    arrayT      array;
    indexT      index;
    dataT       in;
  } heapRequest;

  typedef struct packed {
    dataT      out;
    heapErrorT error;
  } heapResponse;

  typedef struct packed {
    logic  granted;                                 // An array is available
    arrayT array;                                   // Which one
  } allocGrant;

endpackage

`default_nettype wire

//--- heapAllocator.sv
// Array allocator with a stack of freed array numbers
// Tracks the allocation count and one liveness bit per array
// Computes the access check and the Alloc grant
`timescale 1ns/1ps
`default_nettype none

module heapAllocator import heapPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  heapRequest request,
  output accessT     access,
  output allocGrant  grant
);

  logic [AddressBits:0]   allocCount;               // Arrays handed out so far
  logic [AddressBits:0]   freeTop;                  // Entries on the free stack
  arrayT                  freeStack [Arrays];       // Freed array numbers
  logic [Arrays-1:0]      live;                     // One bit per live array
  logic                   doAlloc;
  logic                   doFree;

  //------------------------------------------------------------
  // Access check and grant
  //------------------------------------------------------------
  always_comb begin
    if ({1'b0, request.array} >= allocCount) access = errNotAllocated;
    else if (!live[request.array])             access = errFreed;
    else                                       access = errNone;
  end

  always_comb begin
    if (freeTop != '0) begin                        // Reuse most recently freed
      grant.granted = 1'b1;
      grant.array   = freeStack[freeTop[AddressBits-1:0] - 1'b1];
    end else if (allocCount < (AddressBits+1)'(Arrays)) begin
      grant.granted = 1'b1;                         // Next never-used number
      grant.array   = allocCount[AddressBits-1:0];
    end else begin
      grant.granted = 1'b0;                         // Out of memory
      grant.array   = '0;
    end
  end

  assign doAlloc = (request.action == actAlloc) && grant.granted;
  assign doFree  = (request.action == actFree) && (access == errNone);

  //------------------------------------------------------------
  // State update
  //------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocCount <= '0;
      freeTop    <= '0;
      live       <= '0;
    end else if (doAlloc) begin
      if (freeTop != '0) freeTop <= freeTop - 1'b1; // Pop the free stack
      else               allocCount <= allocCount + 1'b1;
      live[grant.array] <= 1'b1;
    end else if (doFree) begin
      freeTop              <= freeTop + 1'b1;
      live[request.array]  <= 1'b0;
    end
  end

  // Stack never overflows, only live arrays get pushed
  always_ff @(posedge clock) begin
    if (doFree) freeStack[freeTop[AddressBits-1:0]] <= request.array;
  end

endmodule

`default_nettype wire

//--- elementAlu.sv
// Combinational read-modify-write operations on one element
// Picks the old or the new value for the response
`timescale 1ns/1ps
`default_nettype none

module elementAlu import heapPkg::*; (
  input  heapActionT action,
  input  dataT       element,
  input  dataT       operand,
  output dataT       newValue,
  output dataT       reportValue
);

  //------------------------------------------------------------
  // Element update, results wrap to DataBits
  //------------------------------------------------------------
  always_comb begin
    case (action)
      actAdd,
      actAddAfter:    newValue = element + operand;
      actSubtract,
      actSubAfter:    newValue = element - operand;
      actShiftLeft:   newValue = element << operand;  // Large shifts give zero
      actShiftRight:  newValue = element >> operand;
      actNotLogical:  newValue = dataT'(element == '0);
      actNot:         newValue = ~element;
      actOr:          newValue = element | operand;
      actXor:         newValue = element ^ operand;
      actAnd:         newValue = element & operand;
      default:        newValue = element;            // Not an element op
    endcase
  end

  // The two After forms report the value before the update
  always_comb begin
    if (action == actAddAfter || action == actSubAfter) reportValue = element;
    else                                                reportValue = newValue;
  end

endmodule

`default_nettype wire

//--- arrayStore.sv
// Element memory and per-array sizes
// Action decode, Index search and the registered response
`timescale 1ns/1ps
`default_nettype none

module arrayStore import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  heapRequest  request,
  input  accessT      access,
  input  allocGrant   grant,
  input  dataT        newValue,
  input  dataT        reportValue,
  output dataT        element,
  output heapResponse response
);

  dataT      mem   [Arrays][ArrayLength];           // Fixed block per array
  sizeT      sizes [Arrays];                        // Current size of each array
  sizeT      curSize;                               // Size of addressed array
  logic      inBounds;                              // Index below the size
  indexT     popIndex;                              // Last element position
  sizeT      matchPos;                              // Index search result
  dataT      nextOut;
  heapErrorT nextError;
  logic      memWrite;
  indexT     memIndex;
  dataT      memData;
  logic      sizeWrite;
  arrayT     sizeArray;
  sizeT      nextSize;

  assign element  = mem[request.array][request.index];  // To the ALU
  assign curSize  = sizes[request.array];
  assign inBounds = {1'b0, request.index} < curSize;
  assign popIndex = indexT'(curSize - 1'b1);

  //------------------------------------------------------------
  // Index search, last match wins
  //------------------------------------------------------------
  always_comb begin
    matchPos = '0;
    for (int i = 0; i < ArrayLength; i++) begin
      if (sizeT'(i) < curSize && mem[request.array][i] == request.in) begin
        matchPos = sizeT'(i + 1);
      end
    end
  end

  //------------------------------------------------------------
  // Action decode
  //------------------------------------------------------------
  always_comb begin
    nextOut   = response.out;                       // Kept unless set below
    nextError = access;
    memWrite  = 1'b0;
    memIndex  = request.index;
    memData   = request.in;
    sizeWrite = 1'b0;
    sizeArray = request.array;
    nextSize  = curSize;
    if (request.action == actAlloc) begin
      if (grant.granted) begin
        nextError = errNone;
        sizeWrite = 1'b1;                           // Fresh array starts empty
        sizeArray = grant.array;
        nextSize  = '0;
        nextOut   = dataT'(grant.array);
      end else begin
        nextError = errOutOfMemory;
      end
    end else if (access == errNone) begin           // Free needs nothing here
      case (request.action)
        actWrite: begin
          memWrite = 1'b1;
          if (!inBounds) begin                      // Grow to cover the index
            sizeWrite = 1'b1;
            nextSize  = {1'b0, request.index} + 1'b1;
          end
          nextOut = request.in;
        end
        actRead: begin
          if (inBounds) nextOut = element;
          else          nextError = errOutOfBounds;
        end
        actSize:  nextOut = dataT'(curSize);
        actIndex: nextOut = dataT'(matchPos);
        actInc: begin
          if (curSize == sizeT'(ArrayLength)) nextError = errFull;
          else begin
            sizeWrite = 1'b1;
            nextSize  = curSize + 1'b1;
          end
        end
        actDec: begin
          if (curSize == '0) nextError = errEmpty;
          else begin
            sizeWrite = 1'b1;
            nextSize  = curSize - 1'b1;
          end
        end
        actPush: begin
          if (curSize == sizeT'(ArrayLength)) nextError = errFull;
          else begin
            memWrite  = 1'b1;                       // Append at the end
            memIndex  = indexT'(curSize);
            sizeWrite = 1'b1;
            nextSize  = curSize + 1'b1;
          end
        end
        actPop: begin
          if (curSize == '0) nextError = errEmpty;
          else begin
            sizeWrite = 1'b1;
            nextSize  = curSize - 1'b1;
            nextOut   = mem[request.array][popIndex];
          end
        end
        actResize: begin
          if (request.in > dataT'(ArrayLength)) nextError = errOutOfBounds;
          else begin
            sizeWrite = 1'b1;
            nextSize  = sizeT'(request.in);
          end
        end
        actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft,
        actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd: begin
          if (inBounds) begin                       // ALU write back
            memWrite = 1'b1;
            memData  = newValue;
            nextOut  = reportValue;
          end else begin
            nextError = errOutOfBounds;
          end
        end
        default: ;
      endcase
    end
  end

  //------------------------------------------------------------
  // Registers
  //------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (memWrite)  mem[request.array][memIndex] <= memData;
    if (sizeWrite) sizes[sizeArray]             <= nextSize;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      response.out   <= '0;
      response.error <= errNone;
    end else if (request.action != actNone) begin  // Idle holds the response
      response.out   <= nextOut;
      response.error <= nextError;
    end
  end

endmodule

`default_nettype wire

//--- heapTop.sv
// Array heap top level
// Joins the allocator, the array store and the element ALU
`timescale 1ns/1ps
`default_nettype none

module heapTop import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  heapRequest  request,
  output heapResponse response
);

  accessT    access;                                // Liveness of request.array
  allocGrant grant;                                 // Array offered to an Alloc
  dataT      element;                               // Addressed element
  dataT      newValue;                              // Updated element
  dataT      reportValue;                           // Old or new, per action

  heapAllocator i_heapAllocator (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .access  (access),
    .grant   (grant)
  );

  arrayStore i_arrayStore (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .access      (access),
    .grant       (grant),
    .newValue    (newValue),
    .reportValue (reportValue),
    .element     (element),
    .response    (response)
  );

  elementAlu i_elementAlu (
    .action      (request.action),
    .element     (element),
    .operand     (request.in),
    .newValue    (newValue),
    .reportValue (reportValue)
  );

endmodule

`default_nettype wire

//--- heapTbModel.svh
// Shadow copy of the allocator state, sizes and element memory
// Reference functions that give the expected heap response
`ifndef HEAP_TB_MODEL_SVH
`define HEAP_TB_MODEL_SVH

int                modelCount   = 0;                // Never-used numbers handed out
int                modelFreeTop = 0;                // Depth of the free stack
arrayT             modelFreeStack [Arrays];
logic [Arrays-1:0] modelLive    = '0;
sizeT              modelSizes   [Arrays];
dataT              modelMem     [Arrays][ArrayLength];
heapResponse       lastResponse = '0;               // Held across idle and errors

// Element operation as the action table defines it
function automatic dataT applyOp(input heapActionT act, input dataT old, input dataT operand);
  case (act)
    actAdd, actAddAfter:         return old + operand;
    actSubtract, actSubAfter:    return old - operand;
    actShiftLeft:                return old << operand;
    actShiftRight:               return old >> operand;
    actNotLogical:               return (old == '0) ? dataT'(1) : '0;
    actNot:                      return ~old;
    actOr:                       return old | operand;
    actXor:                      return old ^ operand;
    default:                     return old & operand;  // actAnd
  endcase
endfunction

function automatic heapResponse expectResponse(input heapRequest req);
  heapResponse resp;
  heapErrorT   access;
  sizeT        size;
  dataT        old;
  dataT        updated;
  arrayT       slot;
  resp = lastResponse;
  if (req.action == actNone) return resp;           // Idle holds everything
  if (int'(req.array) >= modelCount)  access = errNotAllocated;
  else if (!modelLive[req.array])     access = errFreed;
  else                                access = errNone;
  size       = modelSizes[req.array];
  old        = modelMem[req.array][req.index];
  resp.error = access;
  if (req.action == actAlloc) begin
    resp.error = errNone;
    slot       = '0;
    if (modelFreeTop > 0) begin                     // Most recently freed first
      modelFreeTop--;
      slot = modelFreeStack[modelFreeTop];
    end else if (modelCount < Arrays) begin
      slot = arrayT'(modelCount);
      modelCount++;
    end else begin
      resp.error = errOutOfMemory;
    end
    if (resp.error == errNone) begin
      modelLive[slot]  = 1'b1;
      modelSizes[slot] = '0;
      resp.out         = dataT'(slot);
    end
  end else if (access == errNone) begin
    case (req.action)
      actFree: begin
        modelFreeStack[modelFreeTop] = req.array;
        modelFreeTop++;
        modelLive[req.array] = 1'b0;
      end
      actWrite: begin
        modelMem[req.array][req.index] = req.in;
        if (sizeT'(req.index) >= size) size = sizeT'(req.index) + sizeT'(1);
        resp.out = req.in;
      end
      actRead: begin
        if (sizeT'(req.index) < size) resp.out = old;
        else                          resp.error = errOutOfBounds;
      end
      actSize: resp.out = dataT'(size);
      actInc: begin
        if (size == sizeT'(ArrayLength)) resp.error = errFull;
        else                             size = size + sizeT'(1);
      end
      actDec: begin
        if (size == '0) resp.error = errEmpty;
        else            size = size - sizeT'(1);
      end
      actPush: begin
        if (size == sizeT'(ArrayLength)) resp.error = errFull;
        else begin
          modelMem[req.array][indexT'(size)] = req.in;
          size = size + sizeT'(1);
        end
      end
      actPop: begin
        if (size == '0) resp.error = errEmpty;
        else begin
          size     = size - sizeT'(1);
          resp.out = modelMem[req.array][indexT'(size)];
        end
      end
      actResize: begin
        if (req.in > dataT'(ArrayLength)) resp.error = errOutOfBounds;
        else                              size = sizeT'(req.in);
      end
      actIndex: begin
        resp.out = '0;
        for (int i = 0; i < ArrayLength; i++) begin
          if (sizeT'(i) < size && modelMem[req.array][i] == req.in) resp.out = dataT'(i + 1);
        end
      end
      default: begin                                // Element operations
        if (sizeT'(req.index) < size) begin
          updated = applyOp(req.action, old, req.in);
          modelMem[req.array][req.index] = updated;
          if (req.action == actAddAfter || req.action == actSubAfter) resp.out = old;
          else                                                        resp.out = updated;
        end else begin
          resp.error = errOutOfBounds;
        end
      end
    endcase
    modelSizes[req.array] = size;
  end
  lastResponse = resp;
  return resp;
endfunction

`endif

//--- heapTb.sv
// Array heap testbench
// Directed and random requests checked against the reference model
`timescale 1ns/1ps
`default_nettype none

module heapTb import heapPkg::*; ();

  localparam int ClockPeriod      = 20;
  localparam int DirectedRequests = 113;            // Includes the final idle
  localparam int RandomRequests   = 500;
  localparam int WatchdogNs       = (DirectedRequests + RandomRequests + 20) * ClockPeriod;

  logic        clock = 1'b0;
  logic        reset;
  heapRequest  request;
  heapResponse response;
  heapResponse expectedQueue [$];                   // One entry per driven cycle
  heapResponse expected;

  heapActionT elementOps [11] = '{actAdd, actAddAfter, actSubtract, actSubAfter,
    actShiftLeft, actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd};

  heapTop i_heapTop (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .response (response)
  );

  `include "heapTbModel.svh"

  always #(ClockPeriod / 2) clock = ~clock;

  //------------------------------------------------------------
  // Driving and checking
  //------------------------------------------------------------
  task automatic sendRequest(input heapActionT act, input int arr, input int idx,
                             input dataT data);
    heapRequest req;
    req.action = act;
    req.array  = arrayT'(arr);
    req.index  = indexT'(idx);
    req.in     = data;
    @(posedge clock);
    request <= req;
    expectedQueue.push_back(expectResponse(req));   // Model steps with the DUT
  endtask

  task automatic checkOut(input dataT actual, input dataT wanted);
    if (actual !== wanted) begin
      $display("** Error: response.out expected %h, got %h", wanted, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic checkError(input heapErrorT actual, input heapErrorT wanted);
    if (actual !== wanted) begin
      $display("** Error: response.error expected %h, got %h", wanted, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Response to the previous cycle's request is stable at the falling edge
  always @(negedge clock) begin
    if (expectedQueue.size() >= 2) begin
      expected = expectedQueue.pop_front();
      checkOut(response.out, expected.out);
      checkError(response.error, expected.error);
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the heap run did not complete in the expected time");
    $display("test failed");
    $fatal(1);
  end

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------
  initial begin
    dataT       pushed [ArrayLength + 1];
    dataT       operand;
    dataT       data;
    int         idx;
    heapActionT act;
    void'($urandom(32'h198f));
    reset   = 1'b1;
    request = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    sendRequest(actRead, 0, 0, '0);                 // Nothing allocated yet
    sendRequest(actFree, 0, 0, '0);
    sendRequest(actSize, 0, 0, '0);
    for (int k = 0; k < 5; k++) sendRequest(actAlloc, 0, 0, '0);  // Last one runs out
    for (int a = 0; a < Arrays; a++) begin          // Known contents everywhere
      for (int i = 0; i < ArrayLength; i++) begin
        sendRequest(actWrite, a, i, dataT'(a * 300 + i * 17 + 5));
      end
    end
    sendRequest(actFree, 2, 0, '0);
    sendRequest(actAlloc, 0, 0, '0);                // Gets 2 back
    sendRequest(actFree, 1, 0, '0);
    sendRequest(actRead, 1, 0, '0);                 // Freed
    sendRequest(actWrite, 1, 0, 12'h5a5);
    sendRequest(actAlloc, 0, 0, '0);
    sendRequest(actRead, 1, 0, '0);                 // Size 0 after Alloc
    sendRequest(actWrite, 1, 3, 12'h321);
    sendRequest(actSize, 1, 0, '0);
    sendRequest(actRead, 1, 3, '0);
    sendRequest(actRead, 1, 5, '0);
    sendRequest(actResize, 1, 0, dataT'(ArrayLength));
    sendRequest(actInc, 1, 0, '0);                  // Full
    sendRequest(actResize, 1, 0, dataT'(ArrayLength + 1));
    sendRequest(actResize, 1, 0, '0);
    sendRequest(actDec, 1, 0, '0);                  // Empty
    sendRequest(actInc, 1, 0, '0);
    sendRequest(actSize, 1, 0, '0);
    sendRequest(actResize, 3, 0, '0);
    for (int k = 0; k <= ArrayLength; k++) begin    // One push too many
      pushed[k] = dataT'($urandom);
      if (k == 5) pushed[k] = pushed[2];            // Second copy for the search
      sendRequest(actPush, 3, 0, pushed[k]);
    end
    sendRequest(actIndex, 3, 0, pushed[2]);         // Later copy wins
    sendRequest(actIndex, 3, 0, 12'hfff);
    for (int k = 0; k <= ArrayLength; k++) sendRequest(actPop, 3, 0, '0);
    foreach (elementOps[k]) begin
      act     = elementOps[k];
      idx     = int'($urandom % ArrayLength);
      operand = dataT'($urandom);
      if (act == actShiftLeft || act == actShiftRight) operand = dataT'($urandom % DataBits);
      sendRequest(actWrite, 0, idx, dataT'($urandom));
      sendRequest(act, 0, idx, operand);
      sendRequest(actRead, 0, idx, '0);             // Stored value agrees
    end
    for (int k = 0; k < RandomRequests; k++) begin
      act  = heapActionT'(5'($urandom % 23));
      data = dataT'($urandom);
      if ($urandom % 4 == 0) data = dataT'($urandom % 10);  // Small values for Resize
      sendRequest(act, int'($urandom % Arrays), int'($urandom % ArrayLength), data);
    end
    sendRequest(actNone, 0, 0, '0);
    @(negedge clock);
    #1;
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
heapPkg.sv
heapAllocator.sv
elementAlu.sv
arrayStore.sv
heapTop.sv
heapTb.sv

//--- run.sh
#!/bin/sh
# Build the array heap simulation with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module heapTb -Mdir obj_dir -o heapSim

output=$(./obj_dir/heapSim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi
